/* source/rv32v_pkg.sv */
`default_nettype none

package rv32v_pkg;

    // Banks per vector register and lanes per uop
    localparam int NUM_BANKS = 4;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  vreg_sel_t;

    typedef enum logic [1:0] {
        EEW8  = 2'd0,
        EEW16 = 2'd1,
        EEW32 = 2'd2
    } veew_t;

    typedef enum logic [2:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        AND = 3'd2,
        OR  = 3'd3,
        XOR = 3'd4
    } valu_op_t;

    // Operand A comes from vs1 data, scalar rs1 or immediate
    typedef enum logic [1:0] {
        VV = 2'd0,
        VX = 2'd1,
        VI = 2'd2
    } vsrc_a_t;

    // One word per bank indexed by bank number
    typedef word_t [NUM_BANKS-1:0] lane_t;

    typedef struct packed {
        valu_op_t   op;
        vsrc_a_t    src_a;
        vreg_sel_t  vd;
        vreg_sel_t  vs1;
        vreg_sel_t  vs2;
        veew_t      eew;
        logic       sign_ext;
        logic [1:0] uop_num;
        logic       masked;
        logic [4:0] vl;
        word_t      scalar;
        word_t      imm;
    } vuop_t;

    // Register read record, raw bank words before slot extraction
    typedef struct packed {
        vuop_t uop;
        lane_t src1;
        lane_t src2;
    } vread_t;

    typedef struct packed {
        vreg_sel_t  vd;
        logic [1:0] uop_num;
        veew_t      eew;
        lane_t      alu_res;
        logic [3:0] lane_mask;
    } vexec_t;

    typedef struct packed {
        vreg_sel_t  vd;
        logic [1:0] uop_num;
        lane_t      data;
        logic [3:0] lane_mask;
    } vres_t;

endpackage

`default_nettype wire

/* source/rv32v_uop_queue.sv */
`timescale 1ns/100ps
`default_nettype none

module rv32v_uop_queue
    import rv32v_pkg::*;
#(
    parameter int IN_DEPTH = 4
) (
    input  logic  CLK,
    input  logic  rst_n,
    input  logic  push,
    input  vuop_t push_uop,
    input  logic  pop,
    output vuop_t head,
    output logic  head_valid,
    output logic  credit
);

    localparam int PTR_W = (IN_DEPTH > 1) ? $clog2(IN_DEPTH) : 1;
    localparam int CNT_W = $clog2(IN_DEPTH + 1);

    vuop_t            mem [IN_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(IN_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign head       = mem[rd_ptr];
    assign head_valid = (count != '0);
    assign full       = (count == CNT_W'(IN_DEPTH));

    always_ff @(posedge CLK) begin
        if (push) begin
            mem[wr_ptr] <= push_uop;
        end
    end

    // Every pop frees one slot, handed back to the issuer next cycle
    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= 1'b0;
        end else begin
            credit <= pop;
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    // Issuer credits must keep pushes away from a full queue
    a_no_push_full: assert property (@(posedge CLK) disable iff (!rst_n)
        full |-> !push);

    a_no_pop_empty: assert property (@(posedge CLK) disable iff (!rst_n)
        !head_valid |-> !pop);

endmodule

`default_nettype wire

/* source/rv32v_vector_bank.sv */
`timescale 1ns/100ps
`default_nettype none

module rv32v_vector_bank
    import rv32v_pkg::*;
(
    input  logic       CLK,
    input  logic       rst_n,
    input  vreg_sel_t  vs1,
    input  vreg_sel_t  vs2,
    input  vreg_sel_t  vw,
    input  word_t      vwdata,
    input  logic [3:0] byte_wen,
    output word_t      vdat1,
    output word_t      vdat2,
    output word_t      v0
);

    // One 32-bit slice of each of the 32 vector registers
    word_t regs [32];

    assign vdat1 = regs[vs1];
    assign vdat2 = regs[vs2];

    // v0 slice feeds the mask unit directly
    assign v0 = regs[0];

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            regs <= '{default: '0};
        end else begin
            for (int b = 0; b < 4; b++) begin
                if (byte_wen[b]) begin
                    regs[vw][8*b +: 8] <= vwdata[8*b +: 8];
                end
            end
        end
    end

    // Write enables only ever cover the bytes of one element slot
    a_wen_shape: assert property (@(posedge CLK) disable iff (!rst_n)
        byte_wen inside {4'b0000, 4'b0001, 4'b0010, 4'b0100, 4'b1000,
                         4'b0011, 4'b1100, 4'b1111});

endmodule

`default_nettype wire

/* source/rv32v_read_xbar.sv */
`timescale 1ns/100ps
`default_nettype none

module rv32v_read_xbar
    import rv32v_pkg::*;
(
    input  lane_t      bank_dat,
    input  veew_t      veew,
    input  logic [1:0] slot,
    input  logic       sign_ext,
    output lane_t      out_dat
);

    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_lane
        logic [7:0]  fld8;
        logic [15:0] fld16;

        // Element of this slot within the bank word
        assign fld8  = bank_dat[i][8*slot +: 8];
        assign fld16 = bank_dat[i][16*slot[0] +: 16];

        always_comb begin
            case (veew)
                EEW8: begin
                    if (sign_ext) begin
                        out_dat[i] = {{24{fld8[7]}}, fld8};
                    end else begin
                        out_dat[i] = {24'h0, fld8};
                    end
                end
                EEW16: begin
                    if (sign_ext) begin
                        out_dat[i] = {{16{fld16[15]}}, fld16};
                    end else begin
                        out_dat[i] = {16'h0, fld16};
                    end
                end
                default: out_dat[i] = bank_dat[i];
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/rv32v_mask_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module rv32v_mask_unit
    import rv32v_pkg::*;
(
    input  lane_t      v0,
    input  logic       mask_enable,
    input  logic [1:0] uop_num,
    input  logic [4:0] vl,
    output logic [3:0] lane_mask
);

    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_lane
        logic [4:0] elem_idx;
        logic       in_body;
        logic       mask_bit;

        // Element j sits in bank j mod 4, slot j div 4
        assign elem_idx = {1'b0, uop_num, 2'(i)};
        assign in_body  = (elem_idx < vl);

        // Bit j div 4 of v0 bank j mod 4
        assign mask_bit = v0[i][uop_num];

        assign lane_mask[i] = in_body && (!mask_enable || mask_bit);
    end

endmodule

`default_nettype wire

/* source/rv32v_ex_datapath.sv */
`timescale 1ns/100ps
`default_nettype none

module rv32v_ex_datapath
    import rv32v_pkg::*;
(
    input  logic        CLK,
    input  logic        rst_n,
    input  vuop_t       head,
    input  logic        head_valid,
    input  logic        stall,
    output logic        pop,
    input  vreg_sel_t   wb_vd,
    input  lane_t       wb_data,
    input  logic [15:0] wb_byte_wen,
    output vexec_t      ex_out,
    output logic        ex_valid
);

    vuop_t      iss_uop;
    logic       iss_valid;
    vread_t     rd_rec;
    logic       rd_valid;
    lane_t      bank_src1;
    lane_t      bank_src2;
    lane_t      v0;
    lane_t      xbar_src1;
    lane_t      xbar_src2;
    lane_t      op_a;
    lane_t      alu_raw;
    lane_t      alu_res;
    logic [3:0] lane_mask;

    assign pop = head_valid && !stall;

    // Register banks read at the address of the popped uop
    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        rv32v_vector_bank bank_i (
            .CLK(CLK), .rst_n(rst_n),
            .vs1(iss_uop.vs1), .vs2(iss_uop.vs2),
            .vw(wb_vd), .vwdata(wb_data[b]), .byte_wen(wb_byte_wen[4*b +: 4]),
            .vdat1(bank_src1[b]), .vdat2(bank_src2[b]),
            .v0(v0[b])
        );
    end

    rv32v_read_xbar src1_xbar_i (
        .bank_dat(rd_rec.src1), .veew(rd_rec.uop.eew), .slot(rd_rec.uop.uop_num),
        .sign_ext(rd_rec.uop.sign_ext), .out_dat(xbar_src1)
    );

    rv32v_read_xbar src2_xbar_i (
        .bank_dat(rd_rec.src2), .veew(rd_rec.uop.eew), .slot(rd_rec.uop.uop_num),
        .sign_ext(rd_rec.uop.sign_ext), .out_dat(xbar_src2)
    );

    rv32v_mask_unit mask_i (
        .v0(v0), .mask_enable(rd_rec.uop.masked), .uop_num(rd_rec.uop.uop_num),
        .vl(rd_rec.uop.vl), .lane_mask(lane_mask)
    );

    always_comb begin
        case (rd_rec.uop.src_a)
            VX:      op_a = {NUM_BANKS{rd_rec.uop.scalar}};
            VI:      op_a = {NUM_BANKS{rd_rec.uop.imm}};
            default: op_a = xbar_src1;
        endcase
    end

    // Sub is vs2 minus operand A
    always_comb begin
        for (int i = 0; i < NUM_BANKS; i++) begin
            case (rd_rec.uop.op)
                SUB:     alu_raw[i] = xbar_src2[i] - op_a[i];
                AND:     alu_raw[i] = xbar_src2[i] & op_a[i];
                OR:      alu_raw[i] = xbar_src2[i] | op_a[i];
                XOR:     alu_raw[i] = xbar_src2[i] ^ op_a[i];
                default: alu_raw[i] = xbar_src2[i] + op_a[i];
            endcase
            case (rd_rec.uop.eew)
                EEW8:    alu_res[i] = {24'h0, alu_raw[i][7:0]};
                EEW16:   alu_res[i] = {16'h0, alu_raw[i][15:0]};
                default: alu_res[i] = alu_raw[i];
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            iss_valid <= 1'b0;
            rd_valid  <= 1'b0;
            ex_valid  <= 1'b0;
        end else if (!stall) begin
            iss_valid <= pop;
            rd_valid  <= iss_valid;
            ex_valid  <= rd_valid;
        end
    end

    // Whole pipe holds while writeback waits for a credit
    always_ff @(posedge CLK) begin
        if (!stall) begin
            iss_uop           <= head;
            rd_rec.uop        <= iss_uop;
            rd_rec.src1       <= bank_src1;
            rd_rec.src2       <= bank_src2;
            ex_out.vd         <= rd_rec.uop.vd;
            ex_out.uop_num    <= rd_rec.uop.uop_num;
            ex_out.eew        <= rd_rec.uop.eew;
            ex_out.alu_res    <= alu_res;
            ex_out.lane_mask  <= lane_mask;
        end
    end

    // Slot must exist at this EEW, else the xbar and writeback disagree
    a_slot_range: assert property (@(posedge CLK) disable iff (!rst_n)
        rd_valid |-> (rd_rec.uop.eew == EEW8) ||
                     (rd_rec.uop.eew == EEW16 && !rd_rec.uop.uop_num[1]) ||
                     (rd_rec.uop.eew == EEW32 && rd_rec.uop.uop_num == 2'd0));

endmodule

`default_nettype wire

/* source/rv32v_writeback.sv */
`timescale 1ns/100ps
`default_nettype none

module rv32v_writeback
    import rv32v_pkg::*;
#(
    parameter int OUT_CREDITS = 2
) (
    input  logic        CLK,
    input  logic        rst_n,
    input  vexec_t      ex_in,
    input  logic        ex_valid,
    input  logic        out_credit,
    output logic        out_valid,
    output vres_t       out_res,
    output logic        stall,
    output vreg_sel_t   wb_vd,
    output lane_t       wb_data,
    output logic [15:0] wb_byte_wen
);

    localparam int CNT_W = $clog2(OUT_CREDITS + 1);

    logic [CNT_W-1:0] credit_cnt;
    logic [3:0]       slot_be;

    assign out_valid = ex_valid && (credit_cnt != '0);
    assign stall     = ex_valid && (credit_cnt == '0);

    assign out_res.vd        = ex_in.vd;
    assign out_res.uop_num   = ex_in.uop_num;
    assign out_res.data      = ex_in.alu_res;
    assign out_res.lane_mask = ex_in.lane_mask;

    // Byte lanes of the slot inside each bank word
    always_comb begin
        case (ex_in.eew)
            EEW8:    slot_be = 4'b0001 << ex_in.uop_num;
            EEW16:   slot_be = ex_in.uop_num[0] ? 4'b1100 : 4'b0011;
            default: slot_be = 4'b1111;
        endcase
    end

    assign wb_vd = ex_in.vd;

    always_comb begin
        for (int i = 0; i < NUM_BANKS; i++) begin
            case (ex_in.eew)
                EEW8:    wb_data[i] = ex_in.alu_res[i] << {ex_in.uop_num, 3'b000};
                EEW16:   wb_data[i] = ex_in.alu_res[i] << {ex_in.uop_num[0], 4'b0000};
                default: wb_data[i] = ex_in.alu_res[i];
            endcase
            // Only sent records write, and only their active lanes
            wb_byte_wen[4*i +: 4] = (out_valid && ex_in.lane_mask[i]) ? slot_be : 4'b0000;
        end
    end

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            credit_cnt <= CNT_W'(OUT_CREDITS);
        end else begin
            case ({out_valid, out_credit})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: ;
            endcase
        end
    end

    // Receiver never returns more credits than it was given
    a_credit_cap: assert property (@(posedge CLK) disable iff (!rst_n)
        credit_cnt <= CNT_W'(OUT_CREDITS));

endmodule

`default_nettype wire

/* source/rv32v_ex_top.sv */
`timescale 1ns/100ps
`default_nettype none

module rv32v_ex_top
    import rv32v_pkg::*;
#(
    parameter int IN_DEPTH    = 4,
    parameter int OUT_CREDITS = 2
) (
    input  logic  CLK,
    input  logic  rst_n,
    input  logic  in_valid,
    input  vuop_t in_uop,
    output logic  in_credit,
    input  logic  out_credit,
    output logic  out_valid,
    output vres_t out_res
);

    vuop_t       head;
    logic        head_valid;
    logic        pop;
    logic        stall;
    vexec_t      ex_rec;
    logic        ex_valid;
    vreg_sel_t   wb_vd;
    lane_t       wb_data;
    logic [15:0] wb_byte_wen;

    rv32v_uop_queue #(.IN_DEPTH(IN_DEPTH)) uop_queue_i (
        .CLK(CLK), .rst_n(rst_n),
        .push(in_valid), .push_uop(in_uop),
        .pop(pop), .head(head), .head_valid(head_valid),
        .credit(in_credit)
    );

    rv32v_ex_datapath ex_datapath_i (
        .CLK(CLK), .rst_n(rst_n),
        .head(head), .head_valid(head_valid), .stall(stall), .pop(pop),
        .wb_vd(wb_vd), .wb_data(wb_data), .wb_byte_wen(wb_byte_wen),
        .ex_out(ex_rec), .ex_valid(ex_valid)
    );

    rv32v_writeback #(.OUT_CREDITS(OUT_CREDITS)) writeback_i (
        .CLK(CLK), .rst_n(rst_n),
        .ex_in(ex_rec), .ex_valid(ex_valid), .out_credit(out_credit),
        .out_valid(out_valid), .out_res(out_res), .stall(stall),
        .wb_vd(wb_vd), .wb_data(wb_data), .wb_byte_wen(wb_byte_wen)
    );

endmodule

`default_nettype wire

/* dv/rv32v_ex_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module rv32v_ex_tb
    import rv32v_pkg::*;
();

    localparam int IN_DEPTH    = 4;
    localparam int OUT_CREDITS = 2;
    localparam int WAIT_LIMIT  = 400;

    // One vector line with the uop to issue and its expected result
    typedef struct packed {
        logic [31:0] test_num;
        vuop_t       uop;
        vres_t       exp;
    } vec_t;

    logic  CLK;
    logic  rst_n;
    logic  in_valid;
    vuop_t in_uop;
    logic  in_credit;
    logic  out_credit;
    logic  out_valid;
    vres_t out_res;

    vec_t  vecs[$];
    vuop_t send_q[$];
    vec_t  exp_q[$];
    int    iss_credits;
    int    rx_credits;
    int    owed;
    int    gap;
    int    err_count;
    bit    aborted;

    rv32v_ex_top #(.IN_DEPTH(IN_DEPTH), .OUT_CREDITS(OUT_CREDITS)) rv32v_ex_top_i (
        .CLK(CLK), .rst_n(rst_n),
        .in_valid(in_valid), .in_uop(in_uop), .in_credit(in_credit),
        .out_credit(out_credit), .out_valid(out_valid), .out_res(out_res)
    );

    always #5 CLK = ~CLK;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH time %0t: %s got %08h expected %08h", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic load_vectors();
        int          fd;
        int          code;
        string       line;
        logic [31:0] f [18];
        vec_t        v;
        fd = $fopen("dv/rv32v_ex_vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open the vector file dv/rv32v_ex_vectors.txt");
            err_count++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            // Lines opening with # are comments
            if (line.len() < 2 || line.getc(0) == 8'h23) begin
                continue;
            end
            code = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                           f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                           f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17]);
            if (code != 18) begin
                $display("Vector line has %0d fields instead of 18: %s", code, line);
                err_count++;
                continue;
            end
            v.test_num      = f[0];
            v.uop.op        = valu_op_t'(f[1][2:0]);
            v.uop.src_a     = vsrc_a_t'(f[2][1:0]);
            v.uop.vd        = f[3][4:0];
            v.uop.vs1       = f[4][4:0];
            v.uop.vs2       = f[5][4:0];
            v.uop.eew       = veew_t'(f[6][1:0]);
            v.uop.sign_ext  = f[7][0];
            v.uop.uop_num   = f[8][1:0];
            v.uop.masked    = f[9][0];
            v.uop.vl        = f[10][4:0];
            v.uop.scalar    = f[11];
            v.uop.imm       = f[12];
            v.exp.vd        = f[3][4:0];
            v.exp.uop_num   = f[8][1:0];
            for (int i = 0; i < NUM_BANKS; i++) begin
                v.exp.data[i] = f[13+i];
            end
            v.exp.lane_mask = f[17][3:0];
            vecs.push_back(v);
        end
        $fclose(fd);
    endtask

    // Results must come back in issue order
    task automatic compare_result();
        vec_t e;
        if (exp_q.size() == 0) begin
            $display("Result seen at time %0t while no uop was outstanding", $time);
            err_count++;
            return;
        end
        e = exp_q.pop_front();
        check_value("out_res.vd", 32'(out_res.vd), 32'(e.exp.vd));
        check_value("out_res.uop_num", 32'(out_res.uop_num), 32'(e.exp.uop_num));
        check_value("out_res.lane_mask", 32'(out_res.lane_mask), 32'(e.exp.lane_mask));
        for (int i = 0; i < NUM_BANKS; i++) begin
            if (e.exp.lane_mask[i]) begin
                check_value($sformatf("out_res.data[%0d]", i), out_res.data[i], e.exp.data[i]);
            end
        end
    endtask

    // Receiver and issuer models run on the falling edge
    always @(negedge CLK) begin
        if (rst_n) begin
            if (out_valid) begin
                if (rx_credits == 0) begin
                    $display("out_valid at time %0t without a granted output credit", $time);
                    err_count++;
                end else begin
                    rx_credits--;
                end
                compare_result();
                owed++;
            end
            out_credit = 1'b0;
            if (owed > 0) begin
                if (gap == 0) begin
                    out_credit = 1'b1;
                    owed--;
                    rx_credits++;
                    gap = $urandom % 6;
                end else begin
                    gap--;
                end
            end
            if (in_credit) begin
                iss_credits++;
            end
            if (iss_credits > IN_DEPTH) begin
                $display("Issuer holds %0d credits at time %0t, more than the queue depth",
                         iss_credits, $time);
                err_count++;
            end
            in_valid = 1'b0;
            if (send_q.size() > 0 && iss_credits > 0) begin
                in_uop   = send_q.pop_front();
                in_valid = 1'b1;
                iss_credits--;
            end
        end
    end

    task automatic wait_for_results(output bit ok);
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0 && cycles < WAIT_LIMIT) begin
            @(posedge CLK);
            cycles++;
        end
        ok = (exp_q.size() == 0);
    endtask

    // Both credit pools back to their reset values
    task automatic wait_for_credits(output bit ok);
        int cycles;
        cycles = 0;
        while ((iss_credits != IN_DEPTH || rx_credits != OUT_CREDITS)
               && cycles < WAIT_LIMIT) begin
            @(posedge CLK);
            cycles++;
        end
        ok = (iss_credits == IN_DEPTH && rx_credits == OUT_CREDITS);
    endtask

    initial begin
        bit          ok;
        int          first;
        int          n;
        int          errs_before;
        int          tests_run;
        logic [31:0] cur_test;
        CLK         = 1'b0;
        rst_n       = 1'b0;
        in_valid    = 1'b0;
        in_uop      = '0;
        out_credit  = 1'b0;
        iss_credits = IN_DEPTH;
        rx_credits  = OUT_CREDITS;
        owed        = 0;
        gap         = 0;
        err_count   = 0;
        aborted     = 1'b0;
        tests_run   = 0;
        first       = 0;
        void'($urandom(32'h2e7eae8b));
        load_vectors();
        repeat (3) @(posedge CLK);
        @(negedge CLK);
        rst_n = 1'b1;
        while (first < vecs.size() && !aborted) begin
            @(posedge CLK);
            cur_test    = vecs[first].test_num;
            errs_before = err_count;
            n           = 0;
            while (first + n < vecs.size() && vecs[first + n].test_num == cur_test) begin
                send_q.push_back(vecs[first + n].uop);
                exp_q.push_back(vecs[first + n]);
                n++;
            end
            first += n;
            wait_for_results(ok);
            if (!ok) begin
                $display("Timeout in test %0d with %0d results still missing",
                         cur_test, exp_q.size());
                err_count++;
                aborted = 1'b1;
            end else begin
                wait_for_credits(ok);
                if (!ok) begin
                    $display("Timeout in test %0d, credits issuer %0d of %0d, output %0d of %0d",
                             cur_test, iss_credits, IN_DEPTH, rx_credits, OUT_CREDITS);
                    err_count++;
                    aborted = 1'b1;
                end
            end
            tests_run++;
            $display("test %0d done: %0d uops, %0d errors", cur_test, n, err_count - errs_before);
        end
        $display("%0d tests, %0d uops, %0d errors", tests_run, vecs.size(), err_count);
        if (err_count == 0 && !aborted && vecs.size() > 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* dv/rv32v_ex_vectors.txt */
# test op src vd vs1 vs2 eew sx un mk vl scalar imm lane0 lane1 lane2 lane3 mask, all hex
# op 0 add 1 sub 2 and 3 or 4 xor; src 0 vv 1 vx 2 vi; eew 0 e8 1 e16 2 e32
1 0 2 01 00 1f 2 0 0 0 04 00000000 11111111 11111111 11111111 11111111 11111111 f
1 0 2 02 00 1f 2 0 0 0 04 00000000 00000100 00000100 00000100 00000100 00000100 f
1 0 2 03 00 1f 2 0 0 0 04 00000000 fffffff0 fffffff0 fffffff0 fffffff0 fffffff0 f
1 0 2 05 00 1f 2 0 0 0 04 00000000 01020304 01020304 01020304 01020304 01020304 f
2 0 0 06 01 02 2 0 0 0 04 00000000 00000000 11111211 11111211 11111211 11111211 f
2 1 0 07 03 02 2 0 0 0 04 00000000 00000000 00000110 00000110 00000110 00000110 f
2 1 0 08 01 03 2 0 0 0 04 00000000 00000000 eeeeeedf eeeeeedf eeeeeedf eeeeeedf f
3 0 2 05 00 1f 2 0 0 0 02 00000000 7ffffff0 7ffffff0 7ffffff0 00000000 00000000 3
3 0 2 00 00 1f 2 0 0 0 04 00000000 00000005 00000005 00000005 00000005 00000005 f
3 0 2 00 00 1f 2 0 0 0 02 00000000 00000002 00000002 00000002 00000000 00000000 3
4 0 0 09 05 1f 2 0 0 0 04 00000000 00000000 7ffffff0 7ffffff0 01020304 01020304 f
4 0 0 0a 01 02 2 0 0 1 04 00000000 00000000 00000000 00000000 11111211 11111211 c
5 1 0 0b 01 05 0 0 0 0 10 00000000 00000000 000000df 000000df 000000f3 000000f3 f
5 1 0 1e 01 05 0 1 0 0 10 00000000 00000000 000000df 000000df 000000f3 000000f3 f
5 1 0 0c 01 05 0 1 1 0 10 00000000 00000000 000000ee 000000ee 000000f2 000000f2 f
5 0 0 0d 03 05 1 1 1 0 08 00000000 00000000 00007ffe 00007ffe 00000101 00000101 f
5 1 0 0e 01 03 1 0 0 0 08 00000000 00000000 0000eedf 0000eedf 0000eedf 0000eedf f
5 0 2 0f 00 05 0 0 1 1 10 00000000 00000001 00000000 00000000 00000000 00000000 3
5 0 2 10 00 05 0 0 3 0 0e 00000000 00000010 0000008f 0000008f 00000000 00000000 3
6 2 1 11 00 05 2 0 0 0 04 0f0f0f0f 00000000 0f0f0f00 0f0f0f00 01020304 01020304 f
6 3 1 12 00 02 2 0 0 0 04 80000001 00000000 80000101 80000101 80000101 80000101 f
6 4 1 13 00 01 2 0 0 0 04 ffffffff 00000000 eeeeeeee eeeeeeee eeeeeeee eeeeeeee f
6 4 1 14 00 05 1 0 1 0 08 0000ffff 00000000 00008000 00008000 0000fefd 0000fefd f
7 0 0 15 06 07 2 0 0 0 04 00000000 00000000 11111321 11111321 11111321 11111321 f
7 1 0 16 08 06 2 0 0 0 04 00000000 00000000 22222332 22222332 22222332 22222332 f
7 4 0 17 09 11 2 0 0 0 04 00000000 00000000 70f0f0f0 70f0f0f0 00000000 00000000 f
7 2 0 18 12 13 2 0 0 0 04 00000000 00000000 80000000 80000000 80000000 80000000 f
7 3 0 19 0a 0d 2 0 0 0 04 00000000 00000000 7ffe0000 7ffe0000 11111211 11111211 f
7 0 0 1a 0b 0c 2 0 0 0 04 00000000 00000000 0000eedf 0000eedf 0000f2f3 0000f2f3 f
7 0 0 1b 10 0e 2 0 0 0 04 00000000 00000000 8f00eedf 8f00eedf 0000eedf 0000eedf f
7 1 0 1c 14 0d 1 1 1 0 08 00000000 00000000 0000fffe 0000fffe 00000204 00000204 f

/* src.f */
source/rv32v_pkg.sv
source/rv32v_uop_queue.sv
source/rv32v_vector_bank.sv
source/rv32v_read_xbar.sv
source/rv32v_mask_unit.sv
source/rv32v_ex_datapath.sv
source/rv32v_writeback.sv
source/rv32v_ex_top.sv
dv/rv32v_ex_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module rv32v_ex_tb -f src.f -o rv32v_ex_sim

sim_out=$(./obj_dir/rv32v_ex_sim) || true
printf '%s\n' "$sim_out"

printf '%s\n' "$sim_out" | grep -q "Simulation completed successfully"
